/* cdr/cdr_bb_loop.sv */
`timescale 1ns/10ps
`default_nettype none

module cdr_bb_loop #(
	parameter int Nti = phy_const_pkg::NTI_DEFAULT,
	parameter int Nadc = phy_const_pkg::NADC_DEFAULT,
	parameter int Npi = phy_const_pkg::NPI_DEFAULT
) (
	input wire logic clk_adc_i,
	input wire logic arst_n_i,

	input wire logic [Nti*Nadc-1:0] adcout_i,   // lane 0 lowest
	input wire logic [Nti-1:0] adcout_sign_i,   // 1 means negative

	input wire phy_const_pkg::cdr_mode_e cdr_mode_i,
	input wire logic [Npi-1:0] pi_offset_i,

	output logic [Npi-1:0] pi_ctl_o
);

	// room for Nti terms of +-(2^Nadc - 1)
	localparam int PdW = Nadc + 2 + $clog2(Nti);

	logic [Nadc-1:0] prev_mag_q;   // last lane of previous word
	logic prev_sign_q;
	logic signed [PdW-1:0] pd_sum;
	logic vote_up_q;
	logic vote_dn_q;
	logic [Npi-1:0] integ_q;
	logic [Npi-1:0] integ_step;

	// mueller-muller pd over the lane sequence
	// y_e*d_l - y_l*d_e with y = d*m collapses to d_e*d_l*(m_e - m_l)
	always_comb begin
		logic [Nadc-1:0] mag_e;
		logic [Nadc-1:0] mag_l;
		logic sign_e;
		logic sign_l;
		logic signed [Nadc:0] diff;
		pd_sum = '0;
		mag_e = prev_mag_q;
		sign_e = prev_sign_q;
		for (int k = 0; k < Nti; k++) begin
			mag_l = adcout_i[k*Nadc +: Nadc];
			sign_l = adcout_sign_i[k];
			diff = $signed({1'b0, mag_e}) - $signed({1'b0, mag_l});
			if (sign_e == sign_l)
				pd_sum = pd_sum + PdW'(diff);
			else
				pd_sum = pd_sum - PdW'(diff);
			mag_e = mag_l;
			sign_e = sign_l;
		end
	end

	// stage one: vote and predecessor
	always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prev_mag_q <= '0;
			prev_sign_q <= 1'b0;
			vote_up_q <= 1'b0;
			vote_dn_q <= 1'b0;
		end else begin
			prev_mag_q <= adcout_i[(Nti-1)*Nadc +: Nadc];
			prev_sign_q <= adcout_sign_i[Nti-1];
			vote_up_q <= (pd_sum > 0);
			vote_dn_q <= (pd_sum < 0);
		end
	end

	// +1, -1 (all ones) or 0
	assign integ_step = vote_up_q ? Npi'(1) : (vote_dn_q ? '1 : '0);

	// stage two: integrator and output code, both wrap mod 2^Npi
	always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			integ_q <= '0;
			pi_ctl_o <= '0;
		end else begin
			case (cdr_mode_i)
				phy_const_pkg::CDR_TRACK: integ_q <= integ_q + integ_step;
				phy_const_pkg::CDR_FREEZE: integ_q <= integ_q;
				default: integ_q <= '0;
			endcase
			pi_ctl_o <= integ_q + pi_offset_i;
		end
	end

	freeze_holds: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		cdr_mode_i == phy_const_pkg::CDR_FREEZE |=> $stable(integ_q))
		else $error("cdr integrator moved while frozen");

endmodule

`default_nettype wire

/* common/dbg_reg_pkg.sv */
`default_nettype none

package dbg_reg_pkg;

	// wishbone byte addresses, word aligned
	typedef enum logic [7:0] {
		REG_CTRL      = 8'h00,
		REG_PI_OFFSET = 8'h04,
		REG_STATUS    = 8'h08,  // read only
		REG_DUMP_ADDR = 8'h0C,
		REG_DUMP_DATA = 8'h10,  // read only, bumps dump addr
		REG_ID        = 8'h14   // read only
	} reg_addr_e;

	// ctrl register fields
	localparam int CTRL_MODE_LSB = 0;
	localparam int CTRL_DUMP_CLEAR_BIT = 4;  // self clearing, reads 0

	// status register fields
	localparam int STAT_DUMP_LSB = 0;
	localparam int STAT_PI_LSB = 16;

	localparam logic [31:0] DBG_ID = 32'h5244_0A01;

	// sample dump state machine
	typedef enum logic [1:0] {
		DUMP_IDLE = 2'd0,
		DUMP_FILL = 2'd1,
		DUMP_DONE = 2'd2
	} dump_state_e;

endpackage

`default_nettype wire

/* common/phy_const_pkg.sv */
`default_nettype none

package phy_const_pkg;

	// datapath dimensions, overridden from the top level

	// interleaved adc lanes per clk_adc cycle
	localparam int NTI_DEFAULT = 4;

	localparam int NADC_DEFAULT = 8;       // adc magnitude bits
	localparam int NPI_DEFAULT = 9;        // phase interpolator code bits

	// dump buffer depth in words, one word holds all lanes of a cycle
	localparam int DUMP_DEPTH_DEFAULT = 64;

	// clock recovery loop mode
	typedef enum logic [1:0] {
		CDR_OFF    = 2'd0,  // integrator cleared
		CDR_TRACK  = 2'd1,  // integrator follows the pd votes
		CDR_FREEZE = 2'd2   // integrator holds
	} cdr_mode_e;

endpackage

`default_nettype wire

/* dump/adc_sample_dump.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_sample_dump #(
	parameter int Nti = phy_const_pkg::NTI_DEFAULT,
	parameter int Nadc = phy_const_pkg::NADC_DEFAULT,
	parameter int DumpDepth = phy_const_pkg::DUMP_DEPTH_DEFAULT,
	localparam int DumpAddrW = $clog2(Nti*DumpDepth)
) (
	input wire logic clk_adc_i,
	input wire logic arst_n_i,

	input wire logic [Nti*Nadc-1:0] adcout_i,
	input wire logic [Nti-1:0] adcout_sign_i,

	input wire logic ext_dump_start_i,
	input wire logic dump_clear_i,          // back to idle from done
	input wire logic [DumpAddrW-1:0] dump_rd_addr_i,

	output dbg_reg_pkg::dump_state_e dump_state_o,
	output logic [Nadc:0] dump_rd_data_o    // {sign, magnitude}
);

	localparam int LaneW = Nadc + 1;
	localparam int WordW = Nti*LaneW;
	localparam int WcntW = $clog2(DumpDepth);
	localparam int LaneSelW = $clog2(Nti);

	dbg_reg_pkg::dump_state_e state_q;
	logic trig_q;
	logic trig_rise;
	logic [WcntW-1:0] wcnt_q;
	logic mem_we;
	logic [WordW-1:0] wr_word;
	logic [WcntW-1:0] rd_word_idx;
	logic [LaneSelW-1:0] rd_lane;

	// one row per captured cycle, lane l at bits l*LaneW, so entry word*Nti+lane
	logic [WordW-1:0] mem [DumpDepth];

	assign dump_state_o = state_q;

	// high sample following a low sample
	assign trig_rise = ext_dump_start_i & ~trig_q;
	assign mem_we = (state_q == dbg_reg_pkg::DUMP_FILL);

	always_comb begin
		for (int l = 0; l < Nti; l++) begin
			wr_word[l*LaneW +: LaneW] = {adcout_sign_i[l], adcout_i[l*Nadc +: Nadc]};
		end
	end

	assign rd_word_idx = WcntW'(dump_rd_addr_i / Nti);
	assign rd_lane = LaneSelW'(dump_rd_addr_i % Nti);

	always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= dbg_reg_pkg::DUMP_IDLE;
			trig_q <= 1'b0;
			wcnt_q <= '0;
		end else begin
			trig_q <= ext_dump_start_i;
			case (state_q)
				dbg_reg_pkg::DUMP_IDLE: begin
					if (trig_rise) begin
						state_q <= dbg_reg_pkg::DUMP_FILL;  // word 0 on the next edge
						wcnt_q <= '0;
					end
				end
				dbg_reg_pkg::DUMP_FILL: begin
					if (wcnt_q == WcntW'(DumpDepth-1))
						state_q <= dbg_reg_pkg::DUMP_DONE;
					else
						wcnt_q <= wcnt_q + 1'b1;
				end
				dbg_reg_pkg::DUMP_DONE: begin
					// trigger ignored here
					if (dump_clear_i)
						state_q <= dbg_reg_pkg::DUMP_IDLE;
				end
				default: state_q <= dbg_reg_pkg::DUMP_IDLE;
			endcase
		end
	end

	// capture memory, one synchronous read per cycle
	always_ff @(posedge clk_adc_i) begin
		if (mem_we)
			mem[wcnt_q] <= wr_word;
		dump_rd_data_o <= mem[rd_word_idx][rd_lane*LaneW +: LaneW];
	end

	write_in_fill: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		mem_we |-> dump_state_o == dbg_reg_pkg::DUMP_FILL)
		else $error("dump write outside fill");

	wcnt_in_range: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		wcnt_q < DumpDepth)
		else $error("dump word counter out of range %0d", wcnt_q);

endmodule

`default_nettype wire

/* rx_digital.f */
+incdir+verification
common/phy_const_pkg.sv
common/dbg_reg_pkg.sv
source/wb_debug_regs.sv
cdr/cdr_bb_loop.sv
dump/adc_sample_dump.sv
source/rx_digital_top.sv
verification/tb_rx_digital_top.sv

/* source/rx_digital_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_digital_top #(
	parameter int Nti = phy_const_pkg::NTI_DEFAULT,
	parameter int Nadc = phy_const_pkg::NADC_DEFAULT,
	parameter int Npi = phy_const_pkg::NPI_DEFAULT,
	parameter int DumpDepth = phy_const_pkg::DUMP_DEPTH_DEFAULT,
	localparam int DumpAddrW = $clog2(Nti*DumpDepth)
) (
	input wire logic clk_adc_i,           // adc retiming clock
	input wire logic arst_n_i,

	// adc lanes, lane 0 in the low bits
	input wire logic [Nti*Nadc-1:0] adcout_i,
	input wire logic [Nti-1:0] adcout_sign_i,

	input wire logic ext_dump_start_i,

	// to the analog core
	output logic [Npi-1:0] pi_ctl_o,

	// wishbone classic debug port
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [7:0] wb_adr_i,
	input wire logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o
);

	phy_const_pkg::cdr_mode_e cdr_mode;
	dbg_reg_pkg::dump_state_e dump_state;
	logic [Npi-1:0] pi_offset;
	logic dump_clear;
	logic [DumpAddrW-1:0] dump_rd_addr;
	logic [Nadc:0] dump_rd_data;

	// register block, stands in for the jtag debug interface
	wb_debug_regs #(
		.Nti(Nti),
		.Nadc(Nadc),
		.Npi(Npi),
		.DumpDepth(DumpDepth)
	) wb_debug_regs_i (
		.clk_adc_i(clk_adc_i),
		.arst_n_i(arst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.pi_ctl_i(pi_ctl_o),
		.dump_state_i(dump_state),
		.dump_rd_data_i(dump_rd_data),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.cdr_mode_o(cdr_mode),
		.pi_offset_o(pi_offset),
		.dump_clear_o(dump_clear),
		.dump_rd_addr_o(dump_rd_addr)
	);

	cdr_bb_loop #(
		.Nti(Nti),
		.Nadc(Nadc),
		.Npi(Npi)
	) cdr_bb_loop_i (
		.clk_adc_i(clk_adc_i),
		.arst_n_i(arst_n_i),
		.adcout_i(adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.cdr_mode_i(cdr_mode),
		.pi_offset_i(pi_offset),
		.pi_ctl_o(pi_ctl_o)           // single pi code for all outputs
	);

	adc_sample_dump #(
		.Nti(Nti),
		.Nadc(Nadc),
		.DumpDepth(DumpDepth)
	) adc_sample_dump_i (
		.clk_adc_i(clk_adc_i),
		.arst_n_i(arst_n_i),
		.adcout_i(adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.ext_dump_start_i(ext_dump_start_i),
		.dump_clear_i(dump_clear),
		.dump_rd_addr_i(dump_rd_addr),
		.dump_state_o(dump_state),
		.dump_rd_data_o(dump_rd_data)
	);

endmodule

`default_nettype wire

/* source/wb_debug_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_debug_regs #(
	parameter int Nti = phy_const_pkg::NTI_DEFAULT,
	parameter int Nadc = phy_const_pkg::NADC_DEFAULT,
	parameter int Npi = phy_const_pkg::NPI_DEFAULT,
	parameter int DumpDepth = phy_const_pkg::DUMP_DEPTH_DEFAULT,
	localparam int DumpAddrW = $clog2(Nti*DumpDepth)
) (
	input wire logic clk_adc_i,
	input wire logic arst_n_i,

	// wishbone classic slave
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [7:0] wb_adr_i,
	input wire logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,

	// observation
	input wire logic [Npi-1:0] pi_ctl_i,
	input wire dbg_reg_pkg::dump_state_e dump_state_i,
	input wire logic [Nadc:0] dump_rd_data_i,

	// control
	output phy_const_pkg::cdr_mode_e cdr_mode_o,
	output logic [Npi-1:0] pi_offset_o,
	output logic dump_clear_o,
	output logic [DumpAddrW-1:0] dump_rd_addr_o
);

	localparam int DumpEntries = Nti*DumpDepth;

	dbg_reg_pkg::reg_addr_e reg_addr;
	logic req;
	logic wr_req;
	logic rd_req;
	logic [31:0] rd_data;
	logic [DumpAddrW-1:0] dump_addr_q;
	logic [DumpAddrW-1:0] dump_addr_nxt;

	// illegal mode codes fall back to off
	function automatic phy_const_pkg::cdr_mode_e decode_mode(input logic [1:0] raw);
		phy_const_pkg::cdr_mode_e mode;
		if (raw == phy_const_pkg::CDR_TRACK)
			mode = phy_const_pkg::CDR_TRACK;
		else if (raw == phy_const_pkg::CDR_FREEZE)
			mode = phy_const_pkg::CDR_FREEZE;
		else
			mode = phy_const_pkg::CDR_OFF;
		return mode;
	endfunction

	assign reg_addr = dbg_reg_pkg::reg_addr_e'(wb_adr_i);

	// ~ack forces a dead cycle between two accesses
	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign wr_req = req & wb_we_i;
	assign rd_req = req & ~wb_we_i;

	// address is stable for at least one edge before any request,
	// so the synchronous dump read has settled by the request cycle
	assign dump_rd_addr_o = dump_addr_q;
	assign dump_addr_nxt = (dump_addr_q == DumpAddrW'(DumpEntries-1)) ?
		'0 : dump_addr_q + 1'b1;

	// read mux
	always_comb begin
		rd_data = '0;
		case (reg_addr)
			dbg_reg_pkg::REG_CTRL:
				rd_data[dbg_reg_pkg::CTRL_MODE_LSB +: $bits(cdr_mode_o)] = cdr_mode_o;
			dbg_reg_pkg::REG_PI_OFFSET:
				rd_data[Npi-1:0] = pi_offset_o;
			dbg_reg_pkg::REG_STATUS: begin
				rd_data[dbg_reg_pkg::STAT_DUMP_LSB +: $bits(dump_state_i)] = dump_state_i;
				rd_data[dbg_reg_pkg::STAT_PI_LSB +: Npi] = pi_ctl_i;
			end
			dbg_reg_pkg::REG_DUMP_ADDR:
				rd_data[DumpAddrW-1:0] = dump_addr_q;
			dbg_reg_pkg::REG_DUMP_DATA:
				rd_data[Nadc:0] = dump_rd_data_i;  // sign above magnitude
			dbg_reg_pkg::REG_ID:
				rd_data = dbg_reg_pkg::DBG_ID;
			default:
				rd_data = '0;                       // unmapped reads 0
		endcase
	end

	always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
			cdr_mode_o <= phy_const_pkg::CDR_OFF;
			pi_offset_o <= '0;
			dump_clear_o <= 1'b0;
			dump_addr_q <= '0;
		end else begin
			wb_ack_o <= req;
			wb_dat_o <= rd_req ? rd_data : '0;
			dump_clear_o <= 1'b0;                  // one cycle pulse
			if (wr_req) begin
				case (reg_addr)
					dbg_reg_pkg::REG_CTRL: begin
						cdr_mode_o <= decode_mode(wb_dat_i[dbg_reg_pkg::CTRL_MODE_LSB +: 2]);
						dump_clear_o <= wb_dat_i[dbg_reg_pkg::CTRL_DUMP_CLEAR_BIT];
					end
					dbg_reg_pkg::REG_PI_OFFSET:
						pi_offset_o <= wb_dat_i[Npi-1:0];
					dbg_reg_pkg::REG_DUMP_ADDR:
						dump_addr_q <= wb_dat_i[DumpAddrW-1:0];
					default: ;                         // read only or unmapped
				endcase
			end else if (rd_req && reg_addr == dbg_reg_pkg::REG_DUMP_DATA) begin
				dump_addr_q <= dump_addr_nxt;      // auto increment for burst reads
			end
		end
	end

	ack_single_cycle: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb ack held for more than one cycle");

	mode_legal: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		cdr_mode_o inside {phy_const_pkg::CDR_OFF, phy_const_pkg::CDR_TRACK,
			phy_const_pkg::CDR_FREEZE})
		else $error("illegal cdr mode %0d", cdr_mode_o);

endmodule

`default_nettype wire

/* verification/tb_wb_tasks.svh */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// bus cycles wait at most this many clocks for ack
localparam int WB_TIMEOUT = 20;

// 16 bit galois lfsr stepped once per random bit
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one classic cycle driven on the falling edge and held until ack
task automatic wb_cycle(input logic [7:0] adr, input logic we, input logic [31:0] wdat,
		output logic [31:0] rdat);
	int n;
	@(negedge clk_adc_i);
	wb_cyc_i = 1'b1;
	wb_stb_i = 1'b1;
	wb_we_i = we;
	wb_adr_i = adr;
	wb_dat_i = wdat;
	n = 0;
	do begin
		@(negedge clk_adc_i);
		n++;
	end while (!wb_ack_o && n < WB_TIMEOUT);
	if (!wb_ack_o) begin
		abort_run($sformatf("no wishbone ack from address %02h", adr));
	end else begin
		rdat = wb_dat_o;  // data comes with ack
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	end
endtask

task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
	logic [31:0] unused;
	wb_cycle(adr, 1'b1, dat, unused);
endtask

task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
	wb_cycle(adr, 1'b0, 32'h0, dat);
endtask

// strobe held high through three reads so ack must drop in between
task automatic wb_held_reads(input logic [7:0] adr);
	int n;
	int acks;
	@(negedge clk_adc_i);
	wb_cyc_i = 1'b1;
	wb_stb_i = 1'b1;
	wb_we_i = 1'b0;
	wb_adr_i = adr;
	n = 0;
	acks = 0;
	do begin
		@(negedge clk_adc_i);
		n++;
		if (wb_ack_o)
			acks++;
	end while (acks < 3 && n < WB_TIMEOUT);
	wb_cyc_i = 1'b0;
	wb_stb_i = 1'b0;
	if (acks < 3)
		abort_run($sformatf("only %0d wishbone acks from address %02h", acks, adr));
endtask

// per test result line
task automatic begin_test(input string name);
	test_name = name;
	test_err_start = err_cnt;
endtask

task automatic end_test();
	test_cnt++;
	if (err_cnt == test_err_start) begin
		$display("test %s: ok", test_name);
	end else begin
		$display("test %s: %0d errors", test_name, err_cnt - test_err_start);
		test_fail_cnt++;
	end
endtask

`endif

/* verification/tb_rx_digital_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rx_digital_top;

	localparam int NTI = phy_const_pkg::NTI_DEFAULT;
	localparam int NADC = phy_const_pkg::NADC_DEFAULT;
	localparam int NPI = phy_const_pkg::NPI_DEFAULT;
	localparam int DEPTH = phy_const_pkg::DUMP_DEPTH_DEFAULT;
	localparam int HD = 4096;   // history ring of driven words

	logic clk_adc_i;
	logic arst_n_i;
	logic [NTI*NADC-1:0] adcout_i;
	logic [NTI-1:0] adcout_sign_i;
	logic ext_dump_start_i;
	logic [NPI-1:0] pi_ctl_o;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [7:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack_o;

	string test_name;
	int err_cnt = 0;
	int test_err_start;
	int test_cnt = 0;
	int test_fail_cnt = 0;
	logic [15:0] lfsr_q = 16'd63735;
	int edge_cnt = 0;
	logic [NTI*NADC-1:0] hist_mag [HD];
	logic [NTI-1:0] hist_sign [HD];

	// cdr reference model state
	logic [1:0] mode_m = 2'd0;
	logic [NPI-1:0] off_m = '0;
	logic [NPI-1:0] integ_m;
	logic [NPI-1:0] pi_m;
	int vote_m;
	int prev_y;
	int prev_d;

	rx_digital_top rx_digital_top_i (.*);

	`include "tb_wb_tasks.svh"

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic expect_equal(input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("FAILED %s expected %0h actual %0h", test_name, exp, act);
			err_cnt++;
		end
	endtask

	// keeps the model in step and returns after the ack edge
	task automatic reg_write(input logic [7:0] adr, input logic [31:0] dat);
		wb_write(adr, dat);
		if (adr == dbg_reg_pkg::REG_CTRL)
			mode_m = dat[1:0];
		else if (adr == dbg_reg_pkg::REG_PI_OFFSET)
			off_m = dat[NPI-1:0];
	endtask

	task automatic wait_dump_done();
		logic [31:0] st;
		int n;
		n = 0;
		do begin
			wb_read(dbg_reg_pkg::REG_STATUS, st);
			n++;
		end while (st[1:0] != dbg_reg_pkg::DUMP_DONE && n < 200);
		if (st[1:0] != dbg_reg_pkg::DUMP_DONE)
			abort_run("dump never reached the done state");
	endtask

	// word 0 is the input at the edge after the one that saw the rise
	task automatic check_dump(input int trig_edge);
		logic [31:0] got;
		int idx;
		int lane;
		reg_write(dbg_reg_pkg::REG_DUMP_ADDR, 32'h0);
		for (int k = 0; k < NTI*DEPTH; k++) begin
			wb_read(dbg_reg_pkg::REG_DUMP_DATA, got);
			idx = (trig_edge + 1 + k/NTI) % HD;
			lane = k % NTI;
			expect_equal({hist_sign[idx][lane], hist_mag[idx][lane*NADC +: NADC]}, got);
		end
	endtask

	initial begin
		clk_adc_i = 1'b0;
		forever #20 clk_adc_i = ~clk_adc_i;
	end

	always @(negedge clk_adc_i) begin
		for (int i = 0; i < NTI*NADC; i++) begin
			adcout_i[i] = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
		for (int i = 0; i < NTI; i++) begin
			adcout_sign_i[i] = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
	end

	always @(posedge clk_adc_i) begin
		hist_mag[edge_cnt % HD] = adcout_i;
		hist_sign[edge_cnt % HD] = adcout_sign_i;
		edge_cnt++;
	end

	// pd = y_e*d_l - y_l*d_e over the lane sequence with y = d*m
	always @(posedge clk_adc_i or negedge arst_n_i) begin
		int pd;
		int yl;
		int dl;
		if (!arst_n_i) begin
			integ_m = '0;
			pi_m = '0;
			vote_m = 0;
			prev_y = 0;
			prev_d = 1;
		end else begin
			pi_m = integ_m + off_m;
			if (mode_m == phy_const_pkg::CDR_TRACK)
				integ_m = integ_m + NPI'(vote_m);
			else if (mode_m != phy_const_pkg::CDR_FREEZE)
				integ_m = '0;
			pd = 0;
			for (int k = 0; k < NTI; k++) begin
				dl = adcout_sign_i[k] ? -1 : 1;
				yl = dl * int'(adcout_i[k*NADC +: NADC]);
				pd += prev_y*dl - yl*prev_d;
				prev_y = yl;
				prev_d = dl;
			end
			vote_m = (pd > 0) ? 1 : ((pd < 0) ? -1 : 0);
		end
	end

	pi_matches_model: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		pi_ctl_o == pi_m)
		else begin
			$display("FAILED %s expected %0h actual %0h", test_name, $sampled(pi_m),
				$sampled(pi_ctl_o));
			err_cnt++;
		end

	ack_one_cycle: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else begin
			$display("wishbone ack in %s lasted more than one cycle", test_name);
			err_cnt++;
		end

	initial begin
		logic [31:0] rd;
		logic [NPI-1:0] held;
		int trig_edge;
		arst_n_i = 1'b0;
		adcout_i = '0;
		adcout_sign_i = '0;
		ext_dump_start_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		repeat (4) @(negedge clk_adc_i);

		begin_test("reset");
		expect_equal(32'h0, 32'(wb_ack_o));
		expect_equal(32'h0, 32'(pi_ctl_o));
		arst_n_i = 1'b1;
		wb_read(dbg_reg_pkg::REG_CTRL, rd);
		expect_equal(32'h0, rd);
		wb_read(dbg_reg_pkg::REG_STATUS, rd);
		expect_equal(dbg_reg_pkg::DUMP_IDLE, rd[1:0]);
		end_test();

		begin_test("registers");
		reg_write(dbg_reg_pkg::REG_PI_OFFSET, 32'h1A5);
		wb_read(dbg_reg_pkg::REG_PI_OFFSET, rd);
		expect_equal(32'h1A5, rd);
		reg_write(dbg_reg_pkg::REG_CTRL, 32'h2);
		wb_read(dbg_reg_pkg::REG_CTRL, rd);
		expect_equal(32'h2, rd);
		wb_read(dbg_reg_pkg::REG_ID, rd);
		expect_equal(dbg_reg_pkg::DBG_ID, rd);
		wb_held_reads(dbg_reg_pkg::REG_ID);
		wb_write(8'h40, 32'hFFFF_FFFF);      // unmapped
		wb_read(8'h40, rd);
		expect_equal(32'h0, rd);
		wb_read(dbg_reg_pkg::REG_PI_OFFSET, rd);
		expect_equal(32'h1A5, rd);
		wb_read(dbg_reg_pkg::REG_CTRL, rd);
		expect_equal(32'h2, rd);
		reg_write(dbg_reg_pkg::REG_CTRL, 32'h0);
		end_test();

		begin_test("cdr_off_offset");
		reg_write(dbg_reg_pkg::REG_PI_OFFSET, 32'h0C3);
		repeat (2) @(negedge clk_adc_i);
		expect_equal(32'h0C3, 32'(pi_ctl_o));
		repeat (20) @(negedge clk_adc_i);
		expect_equal(32'h0C3, 32'(pi_ctl_o));
		end_test();

		begin_test("cdr_track_freeze");
		reg_write(dbg_reg_pkg::REG_CTRL, 32'h1);
		repeat (200) @(negedge clk_adc_i);  // model assertion runs every edge
		reg_write(dbg_reg_pkg::REG_CTRL, 32'h2);
		repeat (3) @(negedge clk_adc_i);
		held = pi_ctl_o;
		repeat (50) begin
			@(negedge clk_adc_i);
			expect_equal(32'(held), 32'(pi_ctl_o));
		end
		wb_read(dbg_reg_pkg::REG_STATUS, rd);
		expect_equal(32'(held), 32'(rd[dbg_reg_pkg::STAT_PI_LSB +: NPI]));
		end_test();

		begin_test("dump_capture");
		@(negedge clk_adc_i);
		ext_dump_start_i = 1'b1;
		trig_edge = edge_cnt;                // next edge sees the rise
		@(negedge clk_adc_i);
		ext_dump_start_i = 1'b0;
		wait_dump_done();
		check_dump(trig_edge);
		end_test();

		begin_test("dump_rearm");
		@(negedge clk_adc_i);
		ext_dump_start_i = 1'b1;
		repeat (10) @(negedge clk_adc_i);
		wb_read(dbg_reg_pkg::REG_STATUS, rd);
		expect_equal(dbg_reg_pkg::DUMP_DONE, rd[1:0]);
		reg_write(dbg_reg_pkg::REG_CTRL, 32'h10);
		wb_read(dbg_reg_pkg::REG_STATUS, rd);
		expect_equal(dbg_reg_pkg::DUMP_IDLE, rd[1:0]);
		ext_dump_start_i = 1'b0;
		@(negedge clk_adc_i);
		ext_dump_start_i = 1'b1;
		trig_edge = edge_cnt;
		@(negedge clk_adc_i);
		ext_dump_start_i = 1'b0;
		wait_dump_done();
		check_dump(trig_edge);
		end_test();

		$display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
